/* files.f */
source/tsp_pkg.sv
source/move_dispatch.sv
source/word_permute.sv
source/route_lane.sv
source/route_collector.sv
source/tsp_route_top.sv
sim/tb_clock_gen.sv
sim/tsp_route_properties.sv
sim/tb_tsp_route.sv

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o; // 10 ns period
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* sim/tb_tsp_route.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tsp_route;

    localparam int CITIES        = tsp_pkg::CITIES_DEF;
    localparam int REPLICAS      = tsp_pkg::REPLICAS_DEF;
    localparam int WORDS         = CITIES / 8;
    localparam int CB            = tsp_pkg::CITY_BITS;
    localparam int MAX_ROWS      = 40;
    localparam int STREAM_WINDOW = WORDS + 8;
    localparam int MODE_FIXED    = 0;
    localparam int MODE_RANDOM   = 1; // K and L drawn from the LFSR
    localparam int MODE_IN_BUSY  = 2; // issued during the previous row's stream

    logic                 clk;
    logic                 reset;
    logic                 cmd_valid_i;
    tsp_pkg::replica_t    cmd_replica_i;
    tsp_pkg::move_kind_t  cmd_kind_i;
    tsp_pkg::pos_t        cmd_k_i;
    tsp_pkg::pos_t        cmd_l_i;
    logic                 busy_o;
    logic                 reject_o;
    logic                 out_valid_o;
    tsp_pkg::replica_t    out_replica_o;
    tsp_pkg::word_idx_t   out_index_o;
    tsp_pkg::tour_word_t  out_word_o;
    logic                 out_last_o;

    string                row_name [MAX_ROWS];
    int                   row_rep  [MAX_ROWS];
    tsp_pkg::move_kind_t  row_kind [MAX_ROWS];
    int                   row_k    [MAX_ROWS];
    int                   row_l    [MAX_ROWS];
    int                   row_mode [MAX_ROWS];
    bit                   row_rej  [MAX_ROWS];
    int                   row_count = 0;

    int                   tour [REPLICAS][CITIES]; // software model
    logic [31:0]          lfsr_state;
    int                   value_errors = 0;
    int                   stream_errors = 0;
    int                   cycle_count = 0;
    int                   timeout_limit = 1000;

    tb_clock_gen #(
        .RESET_CYCLES (8)
    ) tb_clock_gen_i (
        .clk_o   (clk),
        .reset_o (reset)
    );

    tsp_route_top #(
        .CITIES   (CITIES),
        .REPLICAS (REPLICAS)
    ) tsp_route_top_i (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_replica_i (cmd_replica_i),
        .cmd_kind_i    (cmd_kind_i),
        .cmd_k_i       (cmd_k_i),
        .cmd_l_i       (cmd_l_i),
        .busy_o        (busy_o),
        .reject_o      (reject_o),
        .out_valid_o   (out_valid_o),
        .out_replica_o (out_replica_o),
        .out_index_o   (out_index_o),
        .out_word_o    (out_word_o),
        .out_last_o    (out_last_o)
    );

    task automatic add_row(input string name, input int rep, input tsp_pkg::move_kind_t kind,
                           input int k, input int l, input int mode, input bit rej);
        row_name[row_count] = name;
        row_rep[row_count]  = rep;
        row_kind[row_count] = kind;
        row_k[row_count]    = k;
        row_l[row_count]    = l;
        row_mode[row_count] = mode;
        row_rej[row_count]  = rej;
        row_count++;
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        repeat (n) begin
            value = (value << 1) | int'(lfsr_state[31]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_equal(input string name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        assert (expected === actual) else begin
            value_errors++;
            $display("Fail %s: %s expected %0h, actual %0h", name, what, expected, actual);
        end
    endtask

    // model of the move rules, written as list surgery on the tour
    task automatic apply_move(input int rep, input tsp_pkg::move_kind_t kind,
                              input int k, input int l);
        int q[$];
        int c;
        int i;
        int j;
        for (int p = 0; p < CITIES; p++) q.push_back(tour[rep][p]);
        case (kind)
            tsp_pkg::OR0: begin
                c = q[k];
                q.delete(k);
                q.insert(l, c);
            end
            tsp_pkg::OR1: begin
                c = q[l];
                q.delete(l);
                q.insert(k, c);
            end
            tsp_pkg::TWO: begin
                i = k;
                j = l;
                while (i < j) begin
                    c = q[i];
                    q[i] = q[j];
                    q[j] = c;
                    i++;
                    j--;
                end
            end
            default: ;
        endcase
        for (int p = 0; p < CITIES; p++) tour[rep][p] = q[p];
    endtask

    function automatic tsp_pkg::tour_word_t expected_word(input int rep, input int w);
        tsp_pkg::tour_word_t word;
        word = '0;
        for (int s = 0; s < 8; s++) begin
            word[s*CB +: CB] = tsp_pkg::city_t'(tour[rep][8 * w + s]);
        end
        return word;
    endfunction

    task automatic drive_command(input int rep, input tsp_pkg::move_kind_t kind,
                                 input int k, input int l);
        cmd_valid_i   = 1'b1;
        cmd_replica_i = tsp_pkg::replica_t'(rep);
        cmd_kind_i    = kind;
        cmd_k_i       = tsp_pkg::pos_t'(k);
        cmd_l_i       = tsp_pkg::pos_t'(l);
    endtask

    // called on a falling edge, returns on a falling edge with the DUT idle
    task automatic run_row(input int i, output bit used_next);
        int  k;
        int  l;
        int  a;
        int  b;
        int  n;
        int  words;
        bit  intruder;
        k = row_k[i];
        l = row_l[i];
        if (row_mode[i] == MODE_RANDOM) begin
            do begin
                draw_bits(CB, a);
                draw_bits(CB, b);
                a = a % CITIES;
                b = b % CITIES;
            end while (a == b);
            k = (a < b) ? a : b;
            l = (a < b) ? b : a;
        end
        intruder  = (i + 1 < row_count) && (row_mode[i+1] == MODE_IN_BUSY);
        used_next = intruder;
        drive_command(row_rep[i], row_kind[i], k, l);
        @(negedge clk);
        cmd_valid_i = 1'b0;
        check_equal(row_name[i], "reject_o", row_rej[i], reject_o);
        check_equal(row_name[i], "busy_o", !row_rej[i], busy_o);
        if (row_rej[i]) begin
            repeat (5) begin
                check_equal(row_name[i], "out_valid_o after reject", 0, out_valid_o);
                @(negedge clk);
            end
            return;
        end
        apply_move(row_rep[i], row_kind[i], k, l);
        n = 1;
        words = 0;
        while (busy_o && n < STREAM_WINDOW) begin
            if (intruder && n == 2) begin
                drive_command(row_rep[i+1], row_kind[i+1], row_k[i+1], row_l[i+1]);
            end
            if (intruder && n == 3) begin
                cmd_valid_i = 1'b0;
                check_equal(row_name[i+1], "reject_o while busy", 1, reject_o);
            end
            if (out_valid_o) begin
                check_equal(row_name[i], "arrival cycle", 4 + words, n);
                check_equal(row_name[i], "replica tag", row_rep[i], out_replica_o);
                check_equal(row_name[i], "word index", words, out_index_o);
                check_equal(row_name[i], "tour word", expected_word(row_rep[i], words),
                            out_word_o);
                check_equal(row_name[i], "last flag", words == WORDS - 1, out_last_o);
                words++;
            end
            @(negedge clk);
            n++;
        end
        cmd_valid_i = 1'b0;
        if (busy_o) begin
            stream_errors++;
            $display("row %s: busy_o did not fall within %0d cycles", row_name[i], n);
        end else begin
            check_equal(row_name[i], "busy_o fall cycle", WORDS + 4, n); // one after last word
        end
        check_equal(row_name[i], "word count", WORDS, words);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int  i;
        bit  used_next;
        int  total;
        cmd_valid_i   = 1'b0;
        cmd_replica_i = '0;
        cmd_kind_i    = tsp_pkg::SHOW;
        cmd_k_i       = '0;
        cmd_l_i       = '0;
        lfsr_state    = 32'hf5bb_f3d0;

        //      name                   rep kind          K   L   mode          reject
        add_row("show_r0",             0, tsp_pkg::SHOW,  0,  0, MODE_FIXED,   0);
        add_row("show_r1",             1, tsp_pkg::SHOW,  0,  0, MODE_FIXED,   0);
        add_row("show_r2",             2, tsp_pkg::SHOW,  0,  0, MODE_FIXED,   0);
        add_row("show_r3",             3, tsp_pkg::SHOW,  0,  0, MODE_FIXED,   0);
        add_row("or0_same_word",       0, tsp_pkg::OR0,   2,  6, MODE_FIXED,   0);
        add_row("or1_undo_same_word",  0, tsp_pkg::OR1,   2,  6, MODE_FIXED,   0);
        add_row("or0_cross_word",      1, tsp_pkg::OR0,   3, 20, MODE_FIXED,   0);
        add_row("or1_undo_cross_word", 1, tsp_pkg::OR1,   3, 20, MODE_FIXED,   0);
        add_row("or0_far",             1, tsp_pkg::OR0,   5, 29, MODE_FIXED,   0);
        add_row("or1_near",            1, tsp_pkg::OR1,   9, 12, MODE_FIXED,   0);
        add_row("two_multi_word",      2, tsp_pkg::TWO,   1, 30, MODE_FIXED,   0);
        add_row("two_full",            2, tsp_pkg::TWO,   0, 31, MODE_FIXED,   0);
        add_row("two_short",           3, tsp_pkg::TWO,   9, 14, MODE_FIXED,   0);
        add_row("reject_equal",        0, tsp_pkg::OR0,   7,  7, MODE_FIXED,   1);
        add_row("reject_reversed",     1, tsp_pkg::TWO,  20,  4, MODE_FIXED,   1);
        add_row("show_busy_host",      2, tsp_pkg::SHOW,  0,  0, MODE_FIXED,   0);
        add_row("reject_busy",         0, tsp_pkg::OR0,   1,  5, MODE_IN_BUSY, 1);
        add_row("rand_two",            0, tsp_pkg::TWO,   0,  0, MODE_RANDOM,  0);
        add_row("rand_or0",            3, tsp_pkg::OR0,   0,  0, MODE_RANDOM,  0);
        add_row("rand_or1",            1, tsp_pkg::OR1,   0,  0, MODE_RANDOM,  0);
        add_row("rand_two_b",          2, tsp_pkg::TWO,   0,  0, MODE_RANDOM,  0);
        add_row("final_show_r0",       0, tsp_pkg::SHOW,  0,  0, MODE_FIXED,   0);
        add_row("final_show_r1",       1, tsp_pkg::SHOW,  0,  0, MODE_FIXED,   0);
        add_row("final_show_r2",       2, tsp_pkg::SHOW,  0,  0, MODE_FIXED,   0);
        add_row("final_show_r3",       3, tsp_pkg::SHOW,  0,  0, MODE_FIXED,   0);
        timeout_limit = row_count * (WORDS + 8) + 20;

        for (int r = 0; r < REPLICAS; r++) begin
            for (int p = 0; p < CITIES; p++) tour[r][p] = p; // identity after reset
        end

        @(negedge clk);
        while (reset) @(negedge clk);
        @(negedge clk);

        i = 0;
        while (i < row_count) begin
            run_row(i, used_next);
            i += used_next ? 2 : 1;
        end

        total = value_errors + stream_errors
              + tsp_route_top_i.tsp_route_properties_i.fail_count;
        $display("errors: value %0d, stream %0d, assertion %0d", value_errors, stream_errors,
                 tsp_route_top_i.tsp_route_properties_i.fail_count);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tsp_route_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module tsp_route_properties #(
    parameter int REPLICAS = 4
) (
    input wire logic                clk,
    input wire logic                reset,
    input wire logic                busy_i,
    input wire logic                reject_i,
    input wire logic                out_valid_i,
    input wire logic                out_last_i,
    input wire logic [REPLICAS-1:0] start_i
);

    int unsigned fail_count = 0; // read by the testbench at the end

    // a stream only starts inside a busy window
    valid_needs_busy: assert property (
        @(posedge clk) disable iff (reset) $rose(out_valid_i) |-> busy_i
    ) else begin
        fail_count++;
        $error("out_valid_o rose while busy_o was low");
    end

    last_needs_valid: assert property (
        @(posedge clk) disable iff (reset) out_last_i |-> out_valid_i
    ) else begin
        fail_count++;
        $error("out_last_o high without out_valid_o");
    end

    reject_not_start: assert property (
        @(posedge clk) disable iff (reset) !(reject_i && (|start_i))
    ) else begin
        fail_count++;
        $error("reject_o and a lane start pulse in the same cycle");
    end

endmodule

bind tsp_route_top tsp_route_properties #(
    .REPLICAS (REPLICAS)
) tsp_route_properties_i (
    .clk         (clk),
    .reset       (reset),
    .busy_i      (busy_o),
    .reject_i    (reject_o),
    .out_valid_i (out_valid_o),
    .out_last_i  (out_last_o),
    .start_i     (start)
);

`default_nettype wire

/* source/move_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module move_dispatch #(
    parameter int REPLICAS = 4
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  cmd_valid_i,
    input  wire tsp_pkg::replica_t     cmd_replica_i,
    input  wire tsp_pkg::move_kind_t   cmd_kind_i,
    input  wire tsp_pkg::pos_t         cmd_k_i,
    input  wire tsp_pkg::pos_t         cmd_l_i,
    input  wire logic                  stream_done_i,
    output logic [REPLICAS-1:0]        start_o,
    output tsp_pkg::move_kind_t        kind_o,
    output tsp_pkg::pos_t              k_o,
    output tsp_pkg::pos_t              l_o,
    output logic                       busy_o,
    output logic                       reject_o
);

    logic range_ok;
    logic accept;

    assign range_ok = (cmd_kind_i == tsp_pkg::SHOW) || (cmd_k_i < cmd_l_i);
    assign accept   = cmd_valid_i && !busy_o && range_ok && (cmd_replica_i < REPLICAS);

    always_ff @(posedge clk) begin
        if (reset) begin
            start_o  <= '0;
            busy_o   <= 1'b0;
            reject_o <= 1'b0;
        end else begin
            start_o  <= accept ? (REPLICAS'(1) << cmd_replica_i) : '0; // one-hot lane select
            reject_o <= cmd_valid_i && !accept;
            if (accept) begin
                busy_o <= 1'b1;
            end else if (stream_done_i) begin
                busy_o <= 1'b0; // drops the cycle after the last word
            end
        end
    end

    // move fields stay put until the next accepted command
    always_ff @(posedge clk) begin
        if (accept) begin
            kind_o <= cmd_kind_i;
            k_o    <= cmd_k_i;
            l_o    <= cmd_l_i;
        end
    end

endmodule

`default_nettype wire

/* source/route_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module route_collector #(
    parameter int CITIES   = 32,
    parameter int REPLICAS = 4
) (
    input  wire logic                                     clk,
    input  wire logic                                     reset,
    input  wire logic [REPLICAS-1:0]                      lane_valid_i,
    input  wire tsp_pkg::word_idx_t [REPLICAS-1:0]        lane_index_i,
    input  wire tsp_pkg::tour_word_t [REPLICAS-1:0]       lane_word_i,
    output logic                                          out_valid_o,
    output tsp_pkg::replica_t                             out_replica_o,
    output tsp_pkg::word_idx_t                            out_index_o,
    output tsp_pkg::tour_word_t                           out_word_o,
    output logic                                          out_last_o,
    output logic                                          stream_done_o
);

    logic                 any_valid;
    tsp_pkg::replica_t    pick_rep;
    tsp_pkg::word_idx_t   pick_index;
    tsp_pkg::tour_word_t  pick_word;

    // only one lane streams at a time, so a plain scan is enough
    always_comb begin
        any_valid  = 1'b0;
        pick_rep   = '0;
        pick_index = '0;
        pick_word  = '0;
        for (int r = 0; r < REPLICAS; r++) begin
            if (lane_valid_i[r]) begin
                any_valid  = 1'b1;
                pick_rep   = tsp_pkg::replica_t'(r);
                pick_index = lane_index_i[r];
                pick_word  = lane_word_i[r];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_o <= 1'b0;
            out_last_o  <= 1'b0;
        end else begin
            out_valid_o <= any_valid;
            out_last_o  <= any_valid && (pick_index == tsp_pkg::word_idx_t'(CITIES/8 - 1));
        end
    end

    always_ff @(posedge clk) begin
        out_replica_o <= pick_rep;
        out_index_o   <= pick_index;
        out_word_o    <= pick_word;
    end

    assign stream_done_o = out_last_o; // frees the dispatcher

endmodule

`default_nettype wire

/* source/route_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module route_lane #(
    parameter int CITIES = 32
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  start_i,
    input  wire tsp_pkg::move_kind_t   kind_i,
    input  wire tsp_pkg::pos_t         k_i,
    input  wire tsp_pkg::pos_t         l_i,
    output logic                       lane_valid_o,
    output tsp_pkg::word_idx_t         lane_index_o,
    output tsp_pkg::tour_word_t        lane_word_o
);

    localparam int WORDS = CITIES / 8;

    typedef enum logic [1:0] {
        IDLE,
        STREAM,
        FLUSH
    } lane_state_e;

    lane_state_e                         state;
    tsp_pkg::word_idx_t                  rd_idx;
    logic                                rd_valid;
    logic                                sel; // active bank
    tsp_pkg::tour_word_t [WORDS-1:0]     bank [2];
    tsp_pkg::tour_word_t [WORDS-1:0]     active_tour;

    assign rd_valid    = (state == STREAM);
    assign active_tour = bank[sel];

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            rd_idx <= '0;
            sel    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    rd_idx <= '0;
                    if (start_i) begin
                        state <= STREAM;
                    end
                end
                STREAM: begin
                    rd_idx <= rd_idx + 1'b1;
                    if (rd_idx == tsp_pkg::word_idx_t'(WORDS - 1)) begin
                        state <= FLUSH; // last read issued
                    end
                end
                FLUSH: begin
                    sel   <= ~sel; // last word lands in shadow bank this cycle
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // identity tour at reset, new words go to the shadow bank
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < WORDS; w++) begin
                for (int s = 0; s < 8; s++) begin
                    bank[0][w][s*tsp_pkg::CITY_BITS +: tsp_pkg::CITY_BITS] <=
                        tsp_pkg::city_t'(8 * w + s);
                end
            end
        end else if (lane_valid_o) begin
            bank[!sel][lane_index_o] <= lane_word_o;
        end
    end

    word_permute #(
        .CITIES (CITIES)
    ) word_permute_i (
        .clk     (clk),
        .reset   (reset),
        .tour_i  (active_tour),
        .index_i (rd_idx),
        .valid_i (rd_valid),
        .kind_i  (kind_i),
        .k_i     (k_i),
        .l_i     (l_i),
        .valid_o (lane_valid_o),
        .index_o (lane_index_o),
        .word_o  (lane_word_o)
    );

endmodule

`default_nettype wire

/* source/tsp_pkg.sv */
`default_nettype none

package tsp_pkg;

    // city numbering width, 5 bits gives up to 32 cities
    localparam int CITY_BITS = 5;

    // defaults picked up by the top level
    localparam int CITIES_DEF   = 32;
    localparam int REPLICAS_DEF = 4;

    localparam int SLOTS         = 8; // cities per tour word
    localparam int WORD_BITS     = SLOTS * CITY_BITS;
    localparam int WORD_IDX_BITS = CITY_BITS - 3;

    typedef logic [CITY_BITS-1:0] city_t;

    typedef logic [CITY_BITS-1:0] pos_t; // position inside a tour

    typedef logic [WORD_IDX_BITS-1:0] word_idx_t;

    // slot s of word w holds position 8w+s, slot 0 in the low bits
    typedef logic [WORD_BITS-1:0] tour_word_t;

    typedef enum logic [1:0] {
        SHOW = 2'd0, // stream unchanged
        OR0  = 2'd1, // city at K moves to L
        OR1  = 2'd2, // city at L moves to K
        TWO  = 2'd3  // reverse K..L
    } move_kind_t;

    typedef logic [1:0] replica_t;

endpackage

`default_nettype wire

/* source/tsp_route_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tsp_route_top #(
    parameter int CITIES   = tsp_pkg::CITIES_DEF,
    parameter int REPLICAS = tsp_pkg::REPLICAS_DEF
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  cmd_valid_i,
    input  wire tsp_pkg::replica_t     cmd_replica_i,
    input  wire tsp_pkg::move_kind_t   cmd_kind_i,
    input  wire tsp_pkg::pos_t         cmd_k_i,
    input  wire tsp_pkg::pos_t         cmd_l_i,
    output logic                       busy_o,
    output logic                       reject_o,
    output logic                       out_valid_o,
    output tsp_pkg::replica_t          out_replica_o,
    output tsp_pkg::word_idx_t         out_index_o,
    output tsp_pkg::tour_word_t        out_word_o,
    output logic                       out_last_o
);

    logic [REPLICAS-1:0]                  start;
    tsp_pkg::move_kind_t                  kind;
    tsp_pkg::pos_t                        k;
    tsp_pkg::pos_t                        l;
    logic                                 stream_done;
    logic [REPLICAS-1:0]                  lane_valid;
    tsp_pkg::word_idx_t [REPLICAS-1:0]    lane_index;
    tsp_pkg::tour_word_t [REPLICAS-1:0]   lane_word;

    move_dispatch #(
        .REPLICAS (REPLICAS)
    ) move_dispatch_i (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_replica_i (cmd_replica_i),
        .cmd_kind_i    (cmd_kind_i),
        .cmd_k_i       (cmd_k_i),
        .cmd_l_i       (cmd_l_i),
        .stream_done_i (stream_done),
        .start_o       (start),
        .kind_o        (kind),
        .k_o           (k),
        .l_o           (l),
        .busy_o        (busy_o),
        .reject_o      (reject_o)
    );

    for (genvar r = 0; r < REPLICAS; r++) begin : g_lane
        route_lane #(
            .CITIES (CITIES)
        ) route_lane_i (
            .clk          (clk),
            .reset        (reset),
            .start_i      (start[r]),
            .kind_i       (kind),
            .k_i          (k),
            .l_i          (l),
            .lane_valid_o (lane_valid[r]),
            .lane_index_o (lane_index[r]),
            .lane_word_o  (lane_word[r])
        );
    end

    route_collector #(
        .CITIES   (CITIES),
        .REPLICAS (REPLICAS)
    ) route_collector_i (
        .clk           (clk),
        .reset         (reset),
        .lane_valid_i  (lane_valid),
        .lane_index_i  (lane_index),
        .lane_word_i   (lane_word),
        .out_valid_o   (out_valid_o),
        .out_replica_o (out_replica_o),
        .out_index_o   (out_index_o),
        .out_word_o    (out_word_o),
        .out_last_o    (out_last_o),
        .stream_done_o (stream_done)
    );

endmodule

`default_nettype wire

/* source/word_permute.sv */
`timescale 1ns/1ps
`default_nettype none

module word_permute #(
    parameter int CITIES = 32
) (
    input  wire logic                                   clk,
    input  wire logic                                   reset,
    input  wire tsp_pkg::tour_word_t [CITIES/8-1:0]     tour_i,
    input  wire tsp_pkg::word_idx_t                     index_i,
    input  wire logic                                   valid_i,
    input  wire tsp_pkg::move_kind_t                    kind_i,
    input  wire tsp_pkg::pos_t                          k_i,
    input  wire tsp_pkg::pos_t                          l_i,
    output logic                                        valid_o,
    output tsp_pkg::word_idx_t                          index_o,
    output tsp_pkg::tour_word_t                         word_o
);

    // old-tour position that feeds new position p
    function automatic tsp_pkg::pos_t src_pos(
        input tsp_pkg::move_kind_t kind,
        input tsp_pkg::pos_t       k,
        input tsp_pkg::pos_t       l,
        input tsp_pkg::pos_t       p
    );
        tsp_pkg::pos_t src;
        src = p;
        case (kind)
            tsp_pkg::TWO: begin
                if (k <= p && p <= l) src = k + l - p; // mirrored inside the range
            end
            tsp_pkg::OR0: begin
                if (k <= p && p < l) begin
                    src = p + 1'b1;
                end else if (p == l) begin
                    src = k;
                end
            end
            tsp_pkg::OR1: begin
                if (k < p && p <= l) begin
                    src = p - 1'b1;
                end else if (p == k) begin
                    src = l;
                end
            end
            default: src = p;
        endcase
        return src;
    endfunction

    tsp_pkg::tour_word_t next_word;

    always_comb begin
        tsp_pkg::pos_t pos;
        tsp_pkg::pos_t src;
        next_word = '0;
        for (int s = 0; s < 8; s++) begin
            pos = {index_i, 3'(s)};
            src = src_pos(kind_i, k_i, l_i, pos);
            next_word[s*tsp_pkg::CITY_BITS +: tsp_pkg::CITY_BITS] =
                tour_i[src[tsp_pkg::CITY_BITS-1:3]][src[2:0]*tsp_pkg::CITY_BITS +: tsp_pkg::CITY_BITS];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        index_o <= index_i;
        word_o  <= next_word;
    end

endmodule

`default_nettype wire
